/* dmem_biu_top.f */
rtl/dmem_biu_pkg.sv
rtl/dmem_align_check.sv
rtl/dmem_pma_check.sv
rtl/biu_data_lanes.sv
rtl/biu_ahb_fsm.sv
rtl/dmem_biu_top.sv
verif/tb_dmem_biu_top.sv

/* rtl/biu_ahb_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module biu_ahb_fsm (
  input  logic                          hclk_i,
  input  logic                          rst_n_i,
  input  logic                          mem_req_i,
  input  dmem_biu_pkg::dmem_req_t       mem_i,
  input  logic                          misaligned_i,
  input  logic                          fault_i,
  input  logic [dmem_biu_pkg::XLEN-1:0] hwdata_i,
  input  logic [dmem_biu_pkg::XLEN-1:0] rdata_i,
  output logic [1:0]                    lane_adr_o,
  output dmem_biu_pkg::mem_size_e       lane_size_o,
  output logic                          lane_unsigned_o,
  output dmem_biu_pkg::ahb_m2s_t        ahb_o,
  input  dmem_biu_pkg::ahb_s2m_t        ahb_i,
  output dmem_biu_pkg::dmem_rsp_t       mem_o
);
  import dmem_biu_pkg::*;

  biu_state_e      state_q;
  logic            hsel_q;
  htrans_e         htrans_q;
  logic            ack_q;
  logic            err_q;
  logic            misaligned_q;

  logic [ALEN-1:0] haddr_q;
  logic [XLEN-1:0] hwdata_q;
  logic            hwrite_q;
  hsize_e          hsize_q;
  logic [XLEN-1:0] rdata_q;

  logic            req_accept;
  logic            data_done;

  function automatic hsize_e to_hsize(input mem_size_e size);
    case (size)
      MEM_BYTE: return HSIZE_BYTE;
      MEM_HALF: return HSIZE_HALF;
      default:  return HSIZE_WORD;
    endcase
  endfunction

  assign req_accept = (state_q == ST_IDLE) && mem_req_i;
  assign data_done  = (state_q == ST_DATA) && ahb_i.hready;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      hsel_q       <= 1'b0;
      htrans_q     <= HTRANS_IDLE;
      ack_q        <= 1'b0;
      err_q        <= 1'b0;
      misaligned_q <= 1'b0;
    end else begin
      // Responses are single-cycle pulses
      ack_q        <= 1'b0;
      err_q        <= 1'b0;
      misaligned_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (mem_req_i) begin
            if (misaligned_i) begin
              misaligned_q <= 1'b1;
              state_q      <= ST_RESP;
            end else if (fault_i) begin
              err_q   <= 1'b1;
              state_q <= ST_RESP;
            end else begin
              hsel_q   <= 1'b1;
              htrans_q <= HTRANS_NONSEQ;
              state_q  <= ST_ADDR;
            end
          end
        end
        // Address phase is always one cycle, nothing else in flight
        ST_ADDR: begin
          hsel_q   <= 1'b0;
          htrans_q <= HTRANS_IDLE;
          state_q  <= ST_DATA;
        end
        ST_DATA: begin
          if (ahb_i.hready) begin
            ack_q   <= !ahb_i.hresp;
            err_q   <= ahb_i.hresp;
            state_q <= ST_RESP;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request payload, captured once and held for the whole transfer
  always_ff @(posedge hclk_i) begin
    if (req_accept) begin
      haddr_q         <= mem_i.adr;
      hwdata_q        <= hwdata_i;
      hwrite_q        <= mem_i.we;
      hsize_q         <= to_hsize(mem_i.size);
      lane_adr_o      <= mem_i.adr[1:0];
      lane_size_o     <= mem_i.size;
      lane_unsigned_o <= mem_i.unsigned_ld;
    end
    if (data_done) begin
      rdata_q <= rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ahb_o.hsel   = hsel_q;
    ahb_o.haddr  = haddr_q;
    ahb_o.hwdata = hwdata_q;
    ahb_o.hwrite = hwrite_q;
    ahb_o.hsize  = hsize_q;
    ahb_o.hburst = HBURST_SINGLE;
    ahb_o.hprot  = HPROT_DATA;
    ahb_o.htrans = htrans_q;
  end

  always_comb begin
    mem_o.rdata      = rdata_q;
    mem_o.ack        = ack_q;
    mem_o.err        = err_q;
    mem_o.misaligned = misaligned_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  nonseq_only_in_addr: assert property (
    @(posedge hclk_i) disable iff (!rst_n_i)
    (ahb_o.htrans == HTRANS_NONSEQ) |-> (state_q == ST_ADDR)
  ) else $error("NONSEQ outside the address phase");

  // Wait states must not disturb anything the slave may still sample
  hold_during_wait: assert property (
    @(posedge hclk_i) disable iff (!rst_n_i)
    (state_q == ST_DATA && !ahb_i.hready) |=> $stable(ahb_o)
  ) else $error("ahb_o changed during a wait state");

  one_response_kind: assert property (
    @(posedge hclk_i) disable iff (!rst_n_i)
    $onehot0({mem_o.ack, mem_o.err, mem_o.misaligned})
  ) else $error("more than one response pulse at once");

endmodule

`default_nettype wire

/* rtl/biu_data_lanes.sv */
`timescale 1ns/10ps
`default_nettype none

module biu_data_lanes (
  input  dmem_biu_pkg::dmem_req_t       mem_i,
  input  logic [1:0]                    lane_adr_i,
  input  dmem_biu_pkg::mem_size_e       lane_size_i,
  input  logic                          lane_unsigned_i,
  input  logic [dmem_biu_pkg::XLEN-1:0] hrdata_i,
  output logic [dmem_biu_pkg::XLEN-1:0] hwdata_o,
  output logic [dmem_biu_pkg::XLEN-1:0] rdata_o
);
  import dmem_biu_pkg::*;

  logic [XLEN-1:0] rd_shifted;

  ////////////////////////////////////////////////////////////////////////////
  // Store path
  ////////////////////////////////////////////////////////////////////////////

  // Replicate so the slave finds the data on whichever lane it decodes
  always_comb begin
    case (mem_i.size)
      MEM_BYTE: hwdata_o = {(XLEN/8){mem_i.wdata[7:0]}};
      MEM_HALF: hwdata_o = {(XLEN/16){mem_i.wdata[15:0]}};
      default:  hwdata_o = mem_i.wdata;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load path
  ////////////////////////////////////////////////////////////////////////////

  // Addressed lane down to bit 0
  assign rd_shifted = hrdata_i >> {lane_adr_i, 3'b000};

  always_comb begin
    case (lane_size_i)
      MEM_BYTE: begin
        if (lane_unsigned_i) begin
          rdata_o = {{(XLEN-8){1'b0}}, rd_shifted[7:0]};
        end else begin
          rdata_o = {{(XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
        end
      end
      MEM_HALF: begin
        if (lane_unsigned_i) begin
          rdata_o = {{(XLEN-16){1'b0}}, rd_shifted[15:0]};
        end else begin
          rdata_o = {{(XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
        end
      end
      default: rdata_o = hrdata_i;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/dmem_align_check.sv */
`timescale 1ns/10ps
`default_nettype none

module dmem_align_check (
  input  dmem_biu_pkg::dmem_req_t mem_i,
  output logic                    misaligned_o
);
  import dmem_biu_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Alignment
  ////////////////////////////////////////////////////////////////////////////

  // Halves need bit 0 clear, words both low bits clear
  always_comb begin
    case (mem_i.size)
      MEM_HALF: misaligned_o = mem_i.adr[0];
      MEM_WORD: misaligned_o = |mem_i.adr[1:0];
      default:  misaligned_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Byte accesses can sit on any address
  byte_never_misaligned: assert property (
    @(mem_i) (mem_i.size == MEM_BYTE) |-> !misaligned_o
  ) else $error("byte request flagged as misaligned, adr %h", mem_i.adr);

endmodule

`default_nettype wire

/* rtl/dmem_biu_pkg.sv */
`default_nettype none

package dmem_biu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN    = 32;
  localparam int ALEN    = 32;
  localparam int PMA_CNT = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed AHB codes
  ////////////////////////////////////////////////////////////////////////////

  // Data access, user mode, non-bufferable, non-cacheable
  localparam logic [3:0] HPROT_DATA    = 4'b0001;

  // Only single transfers are issued
  localparam logic [2:0] HBURST_SINGLE = 3'b000;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_e;

  // BUSY and SEQ never used, bursts are not issued
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_NONSEQ = 2'b10
  } htrans_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_ADDR = 2'd1,
    ST_DATA = 2'd2,
    ST_RESP = 2'd3
  } biu_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  // Load/store request from the requester
  typedef struct packed {
    logic [ALEN-1:0] adr;
    logic            we;
    mem_size_e       size;
    logic            unsigned_ld;
    logic [XLEN-1:0] wdata;
  } dmem_req_t;

  // One-cycle response pulses plus load data
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            ack;
    logic            err;
    logic            misaligned;
  } dmem_rsp_t;

  typedef struct packed {
    logic valid;
    logic readable;
    logic writable;
  } pma_cfg_t;

  // Master to slave
  typedef struct packed {
    logic            hsel;
    logic [ALEN-1:0] haddr;
    logic [XLEN-1:0] hwdata;
    logic            hwrite;
    hsize_e          hsize;
    logic [2:0]      hburst;
    logic [3:0]      hprot;
    htrans_e         htrans;
  } ahb_m2s_t;

  // Slave to master
  typedef struct packed {
    logic [XLEN-1:0] hrdata;
    logic            hready;
    logic            hresp;
  } ahb_s2m_t;

endpackage

`default_nettype wire

/* rtl/dmem_biu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dmem_biu_top (
  input  logic                          hclk_i,
  input  logic                          rst_n_i,

  // Requester side
  input  logic                          mem_req_i,
  input  dmem_biu_pkg::dmem_req_t       mem_i,
  output dmem_biu_pkg::dmem_rsp_t       mem_o,

  // Memory attributes
  input  dmem_biu_pkg::pma_cfg_t        pma_cfg_i [dmem_biu_pkg::PMA_CNT],
  input  logic [dmem_biu_pkg::ALEN-1:0] pma_adr_i [dmem_biu_pkg::PMA_CNT],

  // AHB-Lite master port
  output dmem_biu_pkg::ahb_m2s_t        ahb_o,
  input  dmem_biu_pkg::ahb_s2m_t        ahb_i
);
  import dmem_biu_pkg::*;

  logic            misaligned;
  logic            pma_fault;
  logic [XLEN-1:0] lane_wdata;
  logic [XLEN-1:0] lane_rdata;
  logic [1:0]      lane_adr;
  mem_size_e       lane_size;
  logic            lane_unsigned;

  ////////////////////////////////////////////////////////////////////////////
  // Request checks
  ////////////////////////////////////////////////////////////////////////////

  dmem_align_check align_check_inst (
    .mem_i           ( mem_i         ),
    .misaligned_o    ( misaligned    )
  );

  dmem_pma_check pma_check_inst (
    .mem_i           ( mem_i         ),
    .pma_cfg_i       ( pma_cfg_i     ),
    .pma_adr_i       ( pma_adr_i     ),
    .fault_o         ( pma_fault     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data lanes and bus sequencer
  ////////////////////////////////////////////////////////////////////////////

  biu_data_lanes data_lanes_inst (
    .mem_i           ( mem_i         ),
    .lane_adr_i      ( lane_adr      ),
    .lane_size_i     ( lane_size     ),
    .lane_unsigned_i ( lane_unsigned ),
    .hrdata_i        ( ahb_i.hrdata  ),
    .hwdata_o        ( lane_wdata    ),
    .rdata_o         ( lane_rdata    )
  );

  biu_ahb_fsm ahb_fsm_inst (
    .hclk_i          ( hclk_i        ),
    .rst_n_i         ( rst_n_i       ),
    .mem_req_i       ( mem_req_i     ),
    .mem_i           ( mem_i         ),
    .misaligned_i    ( misaligned    ),
    .fault_i         ( pma_fault     ),
    .hwdata_i        ( lane_wdata    ),
    .rdata_i         ( lane_rdata    ),
    .lane_adr_o      ( lane_adr      ),
    .lane_size_o     ( lane_size     ),
    .lane_unsigned_o ( lane_unsigned ),
    .ahb_o           ( ahb_o         ),
    .ahb_i           ( ahb_i         ),
    .mem_o           ( mem_o         )
  );

endmodule

`default_nettype wire

/* rtl/dmem_pma_check.sv */
`timescale 1ns/10ps
`default_nettype none

module dmem_pma_check (
  input  dmem_biu_pkg::dmem_req_t        mem_i,
  input  dmem_biu_pkg::pma_cfg_t         pma_cfg_i [dmem_biu_pkg::PMA_CNT],
  input  logic [dmem_biu_pkg::ALEN-1:0]  pma_adr_i [dmem_biu_pkg::PMA_CNT],
  output logic                           fault_o
);
  import dmem_biu_pkg::*;

  logic [PMA_CNT-1:0] region_hit;
  logic               match;
  pma_cfg_t           match_cfg;

  ////////////////////////////////////////////////////////////////////////////
  // Region decode
  ////////////////////////////////////////////////////////////////////////////

  // Top-of-range, each region starts where the previous one ends
  for (genvar k = 0; k < PMA_CNT; k++) begin : gen_region
    if (k == 0) begin : gen_first
      assign region_hit[k] = pma_cfg_i[k].valid && (mem_i.adr < pma_adr_i[k]);
    end else begin : gen_next
      assign region_hit[k] = pma_cfg_i[k].valid &&
                             (mem_i.adr >= pma_adr_i[k-1]) &&
                             (mem_i.adr <  pma_adr_i[k]);
    end
  end

  // Walk down so the lowest matching index is the one left standing
  always_comb begin
    match     = 1'b0;
    match_cfg = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        match     = 1'b1;
        match_cfg = pma_cfg_i[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Permissions
  ////////////////////////////////////////////////////////////////////////////

  // Unmapped address, or access type not allowed in the region
  always_comb begin
    if (!match) begin
      fault_o = 1'b1;
    end else if (mem_i.we) begin
      fault_o = !match_cfg.writable;
    end else begin
      fault_o = !match_cfg.readable;
    end
  end

endmodule

`default_nettype wire

/* verif/tb_dmem_biu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dmem_biu_top;
  import dmem_biu_pkg::*;

  localparam int RSP_ACK        = 0;
  localparam int RSP_BUS_ERR    = 1;
  localparam int RSP_PMA_ERR    = 2;
  localparam int RSP_MISALIGNED = 3;
  localparam int REQ_COUNT      = 39;
  localparam int MAX_CYCLES     = 40 * REQ_COUNT;

  logic            hclk;
  logic            rst_n;
  logic            mem_req;
  dmem_req_t       req;
  dmem_rsp_t       rsp;
  pma_cfg_t        pma_cfg [PMA_CNT];
  logic [ALEN-1:0] pma_adr [PMA_CNT];
  ahb_m2s_t        m2s;
  ahb_s2m_t        s2m;

  // Slave model state
  logic [31:0] slave_mem [256];
  logic [31:0] lfsr = 32'hcf3f8ffc;
  ahb_m2s_t    exp_m2s;
  ahb_m2s_t    dp_m2s;
  logic        dp_active;
  logic        dp_err;
  logic        err_step;
  logic [3:0]  be;
  int          wait_left;
  int          low_cnt;
  int          force_wait;
  int          nonseq_cnt;
  int          cycle_cnt;

  dmem_biu_top u_dut (
    .hclk_i    ( hclk    ),
    .rst_n_i   ( rst_n   ),
    .mem_req_i ( mem_req ),
    .mem_i     ( req     ),
    .mem_o     ( rsp     ),
    .pma_cfg_i ( pma_cfg ),
    .pma_adr_i ( pma_adr ),
    .ahb_o     ( m2s     ),
    .ahb_i     ( s2m     )
  );

  initial begin
    hclk = 1'b0;
    forever #20 hclk = ~hclk;
  end

  always @(posedge hclk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_rsp(input dmem_rsp_t act, input dmem_rsp_t exp, input logic with_data);
    if (act.ack !== exp.ack || act.err !== exp.err || act.misaligned !== exp.misaligned ||
        (with_data && act.rdata !== exp.rdata)) begin
      abort_run($sformatf("error at %0t ns: mem_o is %h, expected %h", $time, act, exp));
    end
  endtask

  task automatic check_m2s(input ahb_m2s_t act, input ahb_m2s_t exp);
    if (act !== exp) begin
      abort_run($sformatf("error at %0t ns: ahb_o is %h, expected %h", $time, act, exp));
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h3c, {idx[3:0], idx[7:4]} ^ 8'hc3};
  endfunction

  // Narrow stores show up on every lane
  function automatic logic [31:0] lane_data(input mem_size_e size, input logic [31:0] wdata);
    case (size)
      MEM_BYTE: return {4{wdata[7:0]}};
      MEM_HALF: return {2{wdata[15:0]}};
      default:  return wdata;
    endcase
  endfunction

  function automatic hsize_e size_to_hsize(input mem_size_e size);
    case (size)
      MEM_BYTE: return HSIZE_BYTE;
      MEM_HALF: return HSIZE_HALF;
      default:  return HSIZE_WORD;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // AHB slave model
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge hclk) begin
    if (!rst_n) begin
      s2m.hready = 1'b1;
      s2m.hresp  = 1'b0;
      dp_active  = 1'b0;
    end else if (m2s.htrans == HTRANS_NONSEQ) begin
      nonseq_cnt++;
      check_m2s(m2s, exp_m2s);
      dp_m2s        = exp_m2s;
      dp_m2s.hsel   = 1'b0;
      dp_m2s.htrans = HTRANS_IDLE;
      dp_err        = (m2s.haddr >= 32'ha00) && (m2s.haddr < 32'hb00);
      wait_left     = (force_wait >= 0) ? force_wait : int'(lfsr_bits(2));
      low_cnt       = wait_left + int'(dp_err);
      err_step      = 1'b0;
      dp_active     = 1'b1;
    end else if (dp_active) begin
      // Whole data phase must look like the address phase minus hsel/htrans
      check_m2s(m2s, dp_m2s);
      if (wait_left > 0) begin
        s2m.hready = 1'b0;
        s2m.hresp  = 1'b0;
        wait_left--;
      end else if (dp_err && !err_step) begin
        s2m.hready = 1'b0;
        s2m.hresp  = 1'b1;
        err_step   = 1'b1;
      end else begin
        s2m.hready = 1'b1;
        s2m.hresp  = dp_err;
        s2m.hrdata = dp_err ? 32'h0 : slave_mem[dp_m2s.haddr[9:2]];
        case (dp_m2s.hsize)
          HSIZE_BYTE: be = 4'b0001 << dp_m2s.haddr[1:0];
          HSIZE_HALF: be = 4'b0011 << {dp_m2s.haddr[1], 1'b0};
          default:    be = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
          if (dp_m2s.hwrite && !dp_err && be[b]) begin
            slave_mem[dp_m2s.haddr[9:2]][8*b +: 8] = dp_m2s.hwdata[8*b +: 8];
          end
        end
        dp_active = 1'b0;
      end
    end else begin
      s2m.hready = 1'b1;
      s2m.hresp  = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_req(input logic [31:0] adr, input logic we, input mem_size_e size,
                         input logic uns, input logic [31:0] wdata, input int kind,
                         input logic [31:0] exp_rdata);
    dmem_rsp_t exp;
    int        cycles;
    int        ns_before;
    int        exp_cycles;
    exp_m2s.hsel   = 1'b1;
    exp_m2s.haddr  = adr;
    exp_m2s.hwdata = lane_data(size, wdata);
    exp_m2s.hwrite = we;
    exp_m2s.hsize  = size_to_hsize(size);
    exp_m2s.hburst = 3'b000;
    // Data access, user mode, non-bufferable, non-cacheable
    exp_m2s.hprot  = 4'b0001;
    exp_m2s.htrans = HTRANS_NONSEQ;
    ns_before       = nonseq_cnt;
    req.adr         = adr;
    req.we          = we;
    req.size        = size;
    req.unsigned_ld = uns;
    req.wdata       = wdata;
    mem_req         = 1'b1;
    cycles          = 0;
    do begin
      @(negedge hclk);
      cycles++;
    end while (!(rsp.ack || rsp.err || rsp.misaligned));
    mem_req        = 1'b0;
    exp            = '0;
    exp.ack        = (kind == RSP_ACK);
    exp.err        = (kind == RSP_BUS_ERR) || (kind == RSP_PMA_ERR);
    exp.misaligned = (kind == RSP_MISALIGNED);
    exp.rdata      = exp_rdata;
    check_rsp(rsp, exp, (kind == RSP_ACK) && !we);
    exp_cycles = (kind <= RSP_BUS_ERR) ? 3 + low_cnt : 1;
    if (cycles != exp_cycles) begin
      abort_run($sformatf("error at %0t ns: response after %0d cycles, expected %0d",
                          $time, cycles, exp_cycles));
    end
    if (nonseq_cnt - ns_before != int'(kind <= RSP_BUS_ERR)) begin
      abort_run($sformatf("error at %0t ns: %0d bus transfers for adr %h",
                          $time, nonseq_cnt - ns_before, adr));
    end
    // No second pulse in the idle cycle
    @(negedge hclk);
    check_rsp(rsp, '0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic word_roundtrip();
    logic [31:0] words [8];
    for (int i = 0; i < 8; i++) begin
      words[i] = lfsr_bits(32);
      run_req(32'h100 + 4 * i, 1'b1, MEM_WORD, 1'b0, words[i], RSP_ACK, '0);
    end
    for (int i = 0; i < 8; i++) begin
      run_req(32'h100 + 4 * i, 1'b0, MEM_WORD, 1'b0, 32'h0, RSP_ACK, words[i]);
    end
  endtask

  task automatic byte_half_lanes();
    run_req(32'h40, 1'b1, MEM_WORD, 1'b0, 32'h11223344, RSP_ACK, '0);
    run_req(32'h41, 1'b1, MEM_BYTE, 1'b0, 32'h000000a5, RSP_ACK, '0);
    run_req(32'h40, 1'b0, MEM_WORD, 1'b0, 32'h0, RSP_ACK, 32'h1122a544);
    run_req(32'h41, 1'b0, MEM_BYTE, 1'b0, 32'h0, RSP_ACK, 32'hffffffa5);
    run_req(32'h41, 1'b0, MEM_BYTE, 1'b1, 32'h0, RSP_ACK, 32'h000000a5);
    run_req(32'h42, 1'b1, MEM_HALF, 1'b0, 32'h00008001, RSP_ACK, '0);
    run_req(32'h42, 1'b0, MEM_HALF, 1'b0, 32'h0, RSP_ACK, 32'hffff8001);
    run_req(32'h42, 1'b0, MEM_HALF, 1'b1, 32'h0, RSP_ACK, 32'h00008001);
    run_req(32'h40, 1'b0, MEM_HALF, 1'b0, 32'h0, RSP_ACK, 32'hffffa544);
    run_req(32'h43, 1'b0, MEM_BYTE, 1'b0, 32'h0, RSP_ACK, 32'hffffff80);
    run_req(32'h40, 1'b0, MEM_BYTE, 1'b1, 32'h0, RSP_ACK, 32'h00000044);
  endtask

  task automatic misaligned_requests();
    run_req(32'h41, 1'b0, MEM_HALF, 1'b0, 32'h0, RSP_MISALIGNED, '0);
    run_req(32'h42, 1'b0, MEM_WORD, 1'b0, 32'h0, RSP_MISALIGNED, '0);
    run_req(32'h43, 1'b1, MEM_WORD, 1'b0, 32'h5555aaaa, RSP_MISALIGNED, '0);
    // Misalignment wins over the read-only region too
    run_req(32'h403, 1'b1, MEM_WORD, 1'b0, 32'h12345678, RSP_MISALIGNED, '0);
  endtask

  task automatic pma_faults();
    run_req(32'h404, 1'b1, MEM_WORD, 1'b0, 32'hdeadbeef, RSP_PMA_ERR, '0);
    run_req(32'h1000, 1'b0, MEM_WORD, 1'b0, 32'h0, RSP_PMA_ERR, '0);
    run_req(32'hc00, 1'b1, MEM_BYTE, 1'b0, 32'h0000007e, RSP_PMA_ERR, '0);
    run_req(32'h7f0, 1'b0, MEM_WORD, 1'b0, 32'h0, RSP_ACK, fill_word(8'hfc));
  endtask

  task automatic slave_error_window();
    run_req(32'ha10, 1'b0, MEM_WORD, 1'b0, 32'h0, RSP_BUS_ERR, '0);
    run_req(32'ha24, 1'b1, MEM_HALF, 1'b0, 32'h0000beef, RSP_BUS_ERR, '0);
  endtask

  task automatic long_wait_states();
    force_wait = 6;
    run_req(32'h84, 1'b1, MEM_WORD, 1'b0, 32'h13579bdf, RSP_ACK, '0);
    force_wait = 5;
    run_req(32'h84, 1'b0, MEM_WORD, 1'b0, 32'h0, RSP_ACK, 32'h13579bdf);
    force_wait = -1;
  endtask

  initial begin
    mem_req    = 1'b0;
    req        = '0;
    s2m.hrdata = '0;
    s2m.hready = 1'b1;
    s2m.hresp  = 1'b0;
    force_wait = -1;
    nonseq_cnt = 0;
    cycle_cnt  = 0;
    low_cnt    = 0;
    pma_cfg[0] = 3'b111;
    pma_adr[0] = 32'h400;
    pma_cfg[1] = 3'b110;
    pma_adr[1] = 32'h800;
    pma_cfg[2] = 3'b111;
    pma_adr[2] = 32'hc00;
    pma_cfg[3] = 3'b000;
    pma_adr[3] = 32'h1000;
    for (int i = 0; i < 256; i++) begin
      slave_mem[i] = fill_word(i[7:0]);
    end
    rst_n = 1'b0;
    repeat (3) @(negedge hclk);
    rst_n = 1'b1;
    @(negedge hclk);
    if (m2s.htrans !== HTRANS_IDLE || m2s.hsel !== 1'b0) begin
      abort_run($sformatf("error at %0t ns: bus not idle after reset", $time));
    end
    check_rsp(rsp, '0, 1'b0);
    word_roundtrip();
    byte_half_lanes();
    misaligned_requests();
    pma_faults();
    slave_error_window();
    long_wait_states();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
